// File: files.f
logic/cache_pkg.sv
logic/request_select.sv
logic/tag_stage.sv
logic/data_stage.sv
logic/cache_bank.sv
verification/cache_bank_properties.sv
verification/cache_bank_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := cache_bank_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/cache_bank_tb.sv
`timescale 1ns/100ps

module cache_bank_tb;
    import cache_pkg::*;

    localparam int NUM_LINES    = 16;
    localparam int NUM_REQS     = 400;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int MEM_WORDS    = (1 << LINE_ADDR_BITS) * LINE_WORDS;
    localparam int WATCHDOG_NS  = NUM_REQS * 20 * CLK_PERIOD;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
        int        due;
    } rsp_exp_t;

    typedef struct packed {
        mem_req_t req;
        int       due;
    } mem_exp_t;

    logic       clk;
    logic       rst;
    logic       core_req_valid;
    core_req_t  core_req;
    logic       core_req_ready;
    logic       core_rsp_valid;
    core_rsp_t  core_rsp;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_rsp_valid;
    line_t      mem_rsp_data;

    integer     seed;
    int         issued;
    int         rd_served;
    logic       rd_scheduled;
    int         rd_due;

    // written by the negedge monitor only
    int         neg_cnt;
    int         accepted;
    int         reads_accepted;
    int         rsp_count;
    int         read_hits;
    int         read_misses;
    int         write_hits;
    int         write_misses;
    int         rd_count;
    line_addr_t rd_addr;
    logic       pend_valid;
    word_t      pend_data;
    core_tag_t  pend_tag;
    word_t      mem_words [MEM_WORDS];
    word_t      golden [MEM_WORDS];
    logic       tag_valid [NUM_LINES];
    line_addr_t tag_addr [NUM_LINES];
    rsp_exp_t   rsp_q [$];
    mem_exp_t   mem_q [$];

    cache_bank #(
        .NUM_LINES (NUM_LINES)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic word_t init_word(input int widx);
        return word_t'(widx) * 32'h9e37_79b1 ^ 32'h5ac3_0f1e;
    endfunction

    function automatic int word_index(input line_addr_t addr, input wsel_t wsel);
        return int'({addr, wsel});
    endfunction

    function automatic word_t merge_word(input word_t old, input word_t data, input byteen_t be);
        word_t w;
        w = old;
        for (int b = 0; b < BYTEEN_BITS; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic line_t read_line(input line_addr_t addr);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*WORD_BITS +: WORD_BITS] = mem_words[word_index(addr, wsel_t'(w))];
        end
        return l;
    endfunction

    task automatic reset_models();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = init_word(i);
            golden[i]    = init_word(i);
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            tag_valid[i] = 1'b0;
        end
        rsp_q.delete();
        mem_q.delete();
        {neg_cnt, accepted, reads_accepted, rsp_count, rd_count} = '0;
        {read_hits, read_misses, write_hits, write_misses} = '0;
        pend_valid = 1'b0;
    endtask

    // direct-mapped, no-write-allocate prediction in acceptance order
    task automatic accept_request(input core_req_t r);
        int       idx;
        int       widx;
        logic     hit;
        mem_exp_t em;
        rsp_exp_t er;
        if (pend_valid) begin
            fail_run("a core request was accepted while a read miss was outstanding");
        end
        idx  = r.addr % NUM_LINES;
        widx = word_index(r.addr, r.wsel);
        hit  = tag_valid[idx] && (tag_addr[idx] == r.addr);
        em   = '0;
        em.req.rw   = r.rw;
        em.req.addr = r.addr;
        em.due      = neg_cnt + 3;
        accepted++;
        if (r.rw) begin
            em.req.wsel   = r.wsel;
            em.req.byteen = r.byteen;
            em.req.data   = r.data;
            mem_q.push_back(em);
            golden[widx] = merge_word(golden[widx], r.data, r.byteen);
            if (hit) write_hits++;
            else write_misses++;
        end else begin
            reads_accepted++;
            if (hit) begin
                er.data = golden[widx];
                er.tag  = r.tag;
                er.due  = neg_cnt + 3;
                rsp_q.push_back(er);
                read_hits++;
            end else begin
                mem_q.push_back(em);
                pend_valid    = 1'b1;
                pend_data     = golden[widx];
                pend_tag      = r.tag;
                tag_valid[idx] = 1'b1;
                tag_addr[idx]  = r.addr;
                read_misses++;
            end
        end
    endtask

    task automatic check_rsp_port();
        rsp_exp_t e;
        if (core_rsp_valid) begin
            if (rsp_q.size() == 0 || rsp_q[0].due != neg_cnt) begin
                fail_run($sformatf("unexpected core response with tag %0d at %0t",
                                   core_rsp.tag, $time));
            end else begin
                e = rsp_q.pop_front();
                check_value("core_rsp.data", 128'(core_rsp.data), 128'(e.data));
                check_value("core_rsp.tag", 128'(core_rsp.tag), 128'(e.tag));
                rsp_count++;
            end
        end else if (rsp_q.size() != 0 && rsp_q[0].due <= neg_cnt) begin
            fail_run($sformatf("core response for tag %0d did not arrive in time", rsp_q[0].tag));
        end
    endtask

    task automatic check_mem_port();
        mem_exp_t e;
        if (mem_req_valid) begin
            if (mem_q.size() == 0 || mem_q[0].due != neg_cnt) begin
                fail_run($sformatf("unexpected memory request for line %0d at %0t",
                                   mem_req.addr, $time));
            end else begin
                e = mem_q.pop_front();
                check_value("mem_req.rw", 128'(mem_req.rw), 128'(e.req.rw));
                check_value("mem_req.addr", 128'(mem_req.addr), 128'(e.req.addr));
                if (e.req.rw) begin
                    check_value("mem_req.wsel", 128'(mem_req.wsel), 128'(e.req.wsel));
                    check_value("mem_req.byteen", 128'(mem_req.byteen), 128'(e.req.byteen));
                    check_value("mem_req.data", 128'(mem_req.data), 128'(e.req.data));
                    mem_words[word_index(mem_req.addr, mem_req.wsel)] =
                        merge_word(mem_words[word_index(mem_req.addr, mem_req.wsel)],
                                   mem_req.data, mem_req.byteen);
                end else begin
                    rd_addr = mem_req.addr;
                    rd_count++;
                end
            end
        end else if (mem_q.size() != 0 && mem_q[0].due <= neg_cnt) begin
            fail_run($sformatf("memory request for line %0d did not arrive in time",
                               mem_q[0].req.addr));
        end
    endtask

    task automatic start_fill();
        rsp_exp_t er;
        if (!pend_valid) begin
            fail_run("memory answered without an outstanding read miss");
        end
        er.data = pend_data;
        er.tag  = pend_tag;
        er.due  = neg_cnt + 3;
        rsp_q.push_back(er);
        pend_valid = 1'b0;
    endtask

    // outputs and handshakes are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            reset_models();
        end else begin
            neg_cnt++;
            check_rsp_port();
            check_mem_port();
            if (core_req_valid && core_req_ready) begin
                accept_request(core_req);
            end
            if (mem_rsp_valid) begin
                start_fill();
            end
        end
    end

    task automatic make_request();
        logic [31:0] tmp;
        tmp = $random(seed);
        core_req.rw     = (tmp[18:16] < 3'd3);
        core_req.addr   = {5'd0, tmp[5:1]};
        core_req.wsel   = tmp[7:6];
        core_req.byteen = tmp[11:8];
        core_req.tag    = tmp[15:12];
        core_req.data   = $random(seed);
    endtask

    task automatic drive_cycle();
        logic [31:0] tmp;
        if (core_req_valid && accepted == issued) begin
            core_req_valid = 1'b0;
        end
        if (!core_req_valid && issued < NUM_REQS) begin
            tmp = $random(seed);
            if (tmp[3:0] >= 4'd3) begin
                make_request();
                core_req_valid = 1'b1;
                issued++;
            end
        end
        // memory answers one line read after 3 to 10 cycles
        mem_rsp_valid = 1'b0;
        if (rd_count != rd_served) begin
            if (!rd_scheduled) begin
                tmp = $random(seed);
                rd_due       = neg_cnt + 3 + int'(tmp[2:0]);
                rd_scheduled = 1'b1;
            end
            if (neg_cnt >= rd_due) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = read_line(rd_addr);
                rd_served++;
                rd_scheduled = 1'b0;
            end
        end
    endtask

    initial begin
        seed           = 32'h9697_0b0e;
        rst            = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        issued         = 0;
        rd_served      = 0;
        rd_scheduled   = 1'b0;
        rd_due         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        while (accepted < NUM_REQS || rsp_q.size() != 0 || mem_q.size() != 0 || pend_valid) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_cycle();
        end
        // idle tail catches stray strobes
        repeat (4) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_cycle();
        end
        if (rsp_count == reads_accepted && read_hits > 0 && read_misses > 0
                && write_hits > 0 && write_misses > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run({$sformatf("wrong response count or mix: %0d responses, %0d reads, ",
                                rsp_count, reads_accepted),
                      $sformatf("%0d/%0d read hits/misses, %0d/%0d write hits/misses",
                                read_hits, read_misses, write_hits, write_misses)});
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all requests were answered");
    end

endmodule

// File: verification/cache_bank_properties.sv
`timescale 1ns/100ps

module cache_bank_properties (
    input logic clk,
    input logic rst,
    input logic core_req_ready,
    input logic core_rsp_valid,
    input logic mem_req_valid,
    input logic mem_req_rw,
    input logic mem_rsp_valid
);

    logic read_out;

    // a line read is open from its request until the memory answers
    always_ff @(posedge clk) begin
        if (rst) begin
            read_out <= 1'b0;
        end else if (mem_req_valid && !mem_req_rw) begin
            read_out <= 1'b1;
        end else if (mem_rsp_valid) begin
            read_out <= 1'b0;
        end
    end

    strobes_low_after_reset: assert property (@(posedge clk)
        rst |=> !core_rsp_valid && !mem_req_valid && !core_req_ready)
        else $error("response or memory strobe high right after reset");

    ready_low_on_miss: assert property (@(posedge clk) disable iff (rst)
        (read_out || mem_rsp_valid) |-> !core_req_ready)
        else $error("core_req_ready high while a memory read is outstanding");

endmodule

bind cache_bank cache_bank_properties cache_bank_properties_i (
    .clk            (clk),
    .rst            (rst),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req_rw     (mem_req.rw),
    .mem_rsp_valid  (mem_rsp_valid)
);

// File: logic/cache_bank.sv
`timescale 1ns/100ps

module cache_bank #(
    parameter int NUM_LINES = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 core_req_valid,
    input  cache_pkg::core_req_t core_req,
    output logic                 core_req_ready,

    output logic                 core_rsp_valid,
    output cache_pkg::core_rsp_t core_rsp,

    output logic                 mem_req_valid,
    output cache_pkg::mem_req_t  mem_req,

    input  logic                 mem_rsp_valid,
    input  cache_pkg::line_t     mem_rsp_data
);
    import cache_pkg::*;

    stage_t st0;
    stage_t st1;
    logic   read_miss;

    // stage 0, fill or core request
    request_select request_select_i (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .read_miss      (read_miss),
        .st0            (st0)
    );

    // tag lookup in stage 0, registered into stage 1
    tag_stage #(
        .NUM_LINES (NUM_LINES)
    ) tag_stage_i (
        .clk       (clk),
        .rst       (rst),
        .st0       (st0),
        .read_miss (read_miss),
        .st1       (st1)
    );

    data_stage #(
        .NUM_LINES (NUM_LINES)
    ) data_stage_i (
        .clk            (clk),
        .rst            (rst),
        .st1            (st1),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

endmodule

// File: logic/data_stage.sv
`timescale 1ns/100ps

module data_stage #(
    parameter int NUM_LINES = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::stage_t    st1,
    output logic                 core_rsp_valid,
    output cache_pkg::core_rsp_t core_rsp,
    output logic                 mem_req_valid,
    output cache_pkg::mem_req_t  mem_req
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_LINES);

    logic [IDX_BITS-1:0] idx;
    line_t               data_q [NUM_LINES];
    line_t               old_line;
    line_t               new_line;
    word_t               old_word;
    word_t               merged_word;
    word_t               rsp_word;
    logic                do_fill;
    logic                do_write;
    logic                do_rsp;
    logic                do_mem_req;

    function automatic word_t get_word(line_t line, wsel_t wsel);
        return line[wsel*WORD_BITS +: WORD_BITS];
    endfunction

    assign idx      = st1.addr[IDX_BITS-1:0];
    assign old_line = data_q[idx];
    assign old_word = get_word(old_line, st1.wsel);

    assign do_fill  = st1.valid && st1.is_fill;
    assign do_write = st1.valid && st1.is_write && st1.hit;

    // byte merge for a write hit
    always_comb begin
        for (int b = 0; b < BYTEEN_BITS; b++) begin
            merged_word[b*8 +: 8] = st1.byteen[b] ? st1.data[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    always_comb begin
        new_line = old_line;
        new_line[st1.wsel*WORD_BITS +: WORD_BITS] = merged_word;
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            data_q[idx] <= st1.line;
        end else if (do_write) begin
            data_q[idx] <= new_line;
        end
    end

    // fill answers from the incoming line, the store is written on the same edge
    assign rsp_word = st1.is_fill ? get_word(st1.line, st1.wsel) : old_word;

    assign do_rsp     = st1.valid && (st1.is_fill || (st1.is_read && st1.hit));
    assign do_mem_req = st1.valid && (st1.is_write || (st1.is_read && !st1.hit));

    always_ff @(posedge clk) begin
        if (rst) begin
            core_rsp_valid <= 1'b0;
            mem_req_valid  <= 1'b0;
        end else begin
            core_rsp_valid <= do_rsp;
            mem_req_valid  <= do_mem_req;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rsp) begin
            core_rsp.data <= rsp_word;
            core_rsp.tag  <= st1.tag;
        end
    end

    // write-through for every write, line read for a read miss
    always_ff @(posedge clk) begin
        if (do_mem_req) begin
            mem_req.rw     <= st1.is_write;
            mem_req.addr   <= st1.addr;
            mem_req.wsel   <= st1.wsel;
            mem_req.byteen <= st1.byteen;
            mem_req.data   <= st1.data;
        end
    end

endmodule

// File: logic/tag_stage.sv
`timescale 1ns/100ps

module tag_stage #(
    parameter int NUM_LINES = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::stage_t st0,
    output logic              read_miss,
    output cache_pkg::stage_t st1
);
    import cache_pkg::*;

    // index is the low bits of the line address, at least 2 lines
    localparam int IDX_BITS = $clog2(NUM_LINES);

    logic [IDX_BITS-1:0]  idx;
    logic [NUM_LINES-1:0] valid_q;
    line_addr_t           addr_q [NUM_LINES];
    logic                 hit;
    logic                 do_fill;
    stage_t               st1_d;

    assign idx     = st0.addr[IDX_BITS-1:0];
    assign do_fill = st0.valid && st0.is_fill;

    // full line address is stored, so the compare needs no tag slicing
    assign hit = valid_q[idx] && (addr_q[idx] == st0.addr);

    assign read_miss = st0.valid && st0.is_read && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (do_fill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            addr_q[idx] <= st0.addr;
        end
    end

    always_comb begin
        st1_d     = st0;
        st1_d.hit = hit;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st1.valid <= 1'b0;
        end else begin
            st1 <= st1_d;
        end
    end

endmodule

// File: logic/request_select.sv
`timescale 1ns/100ps

module request_select (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 core_req_valid,
    input  cache_pkg::core_req_t core_req,
    output logic                 core_req_ready,
    input  logic                 mem_rsp_valid,
    input  cache_pkg::line_t     mem_rsp_data,
    input  logic                 read_miss,
    output cache_pkg::stage_t    st0
);
    import cache_pkg::*;

    logic       active;
    logic       miss_pending;
    line_addr_t pend_addr;
    wsel_t      pend_wsel;
    core_tag_t  pend_tag;
    logic       core_fire;
    stage_t     st0_d;

    // hold the core while a read is being looked up or its miss is open
    assign core_req_ready = active && !miss_pending && !mem_rsp_valid
                         && !(st0.valid && st0.is_read);

    assign core_fire = core_req_valid && core_req_ready;

    always_comb begin
        st0_d = '0;
        if (mem_rsp_valid) begin
            // fill replays the waiting read
            st0_d.valid   = 1'b1;
            st0_d.is_fill = 1'b1;
            st0_d.addr    = pend_addr;
            st0_d.wsel    = pend_wsel;
            st0_d.tag     = pend_tag;
            st0_d.line    = mem_rsp_data;
        end else begin
            st0_d.valid    = core_fire;
            st0_d.is_read  = !core_req.rw;
            st0_d.is_write = core_req.rw;
            st0_d.addr     = core_req.addr;
            st0_d.wsel     = core_req.wsel;
            st0_d.byteen   = core_req.byteen;
            st0_d.data     = core_req.data;
            st0_d.tag      = core_req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_pending <= 1'b0;
        end else if (read_miss) begin
            miss_pending <= 1'b1;
        end else if (mem_rsp_valid) begin
            miss_pending <= 1'b0;
        end
    end

    // remember who is waiting on the line
    always_ff @(posedge clk) begin
        if (read_miss) begin
            pend_addr <= st0.addr;
            pend_wsel <= st0.wsel;
            pend_tag  <= st0.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st0.valid <= 1'b0;
        end else begin
            st0 <= st0_d;
        end
    end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    localparam int WORD_BITS      = 32;
    localparam int LINE_WORDS     = 4;
    localparam int LINE_ADDR_BITS = 10;
    localparam int CORE_TAG_BITS  = 4;

    localparam int BYTEEN_BITS = WORD_BITS / 8;
    localparam int WSEL_BITS   = $clog2(LINE_WORDS);
    localparam int LINE_BITS   = WORD_BITS * LINE_WORDS;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [BYTEEN_BITS-1:0]    byteen_t;
    typedef logic [WSEL_BITS-1:0]      wsel_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [CORE_TAG_BITS-1:0]  core_tag_t;
    typedef logic [LINE_BITS-1:0]      line_t;

    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    // read asks for the whole line, write carries one word
    typedef struct packed {
        logic       rw;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
    } mem_req_t;

    // payload between pipeline stages, hit is filled in by the tag stage
    typedef struct packed {
        logic       valid;
        logic       is_fill;
        logic       is_read;
        logic       is_write;
        logic       hit;
        line_addr_t addr;
        wsel_t      wsel;
        byteen_t    byteen;
        word_t      data;
        core_tag_t  tag;
        line_t      line;
    } stage_t;

endpackage
